// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // widths that carry a meaning
    typedef logic [31:0] xlen_t;
    typedef logic [31:2] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes of the supported groups
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    typedef enum logic [1:0] {OP1_REG, OP1_PC, OP1_ZERO} op1_sel_e;

    typedef enum logic {OP2_REG, OP2_IMM} op2_sel_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} res_src_e;

    // branch codes give a nonzero result when taken
    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } alu_ctrl_e;

    typedef struct packed {
        xlen_t instr;
        pc_t   pc;
        pc_t   pc_p4;
        xlen_t rs1_val;
        xlen_t rs2_val;
    } issue_t;

    typedef struct packed {
        pc_t       pc;
        pc_t       pc_p4;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        reg_idx_t  rd;
        xlen_t     imm;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        res_src_e  res_src;
        logic      pc_sel;
        logic      jump;
        logic      branch;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        funct3_t   funct3;
        alu_ctrl_e alu_ctrl;
    } dec_t;

    typedef struct packed {
        xlen_t    alu_result;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        reg_idx_t rd;
        pc_t      pc_p4;
        res_src_e res_src;
        funct3_t  funct3;
        xlen_t    rs2_val;
        logic     pc_src;
        pc_t      pc_target;
    } exec_res_t;

endpackage

`default_nettype wire

// File: logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
(
    input  wire rv_pkg::xlen_t      i_src_a,
    input  wire rv_pkg::xlen_t      i_src_b,
    input  wire rv_pkg::alu_ctrl_e  i_ctrl,
    output rv_pkg::xlen_t           o_result,
    output logic                    o_zero
);

    logic [4:0] w_shamt;
    logic       w_lt;
    logic       w_ltu;
    logic       w_eq;

    assign w_shamt = i_src_b[4:0];
    assign w_lt    = $signed(i_src_a) < $signed(i_src_b);
    assign w_ltu   = i_src_a < i_src_b;
    assign w_eq    = i_src_a == i_src_b;

    always_comb
    begin
        case (i_ctrl)
            rv_pkg::ADD:    o_result = i_src_a + i_src_b;
            rv_pkg::SUB:    o_result = i_src_a - i_src_b;
            rv_pkg::SLL:    o_result = i_src_a << w_shamt;
            rv_pkg::SLT:    o_result = {31'b0, w_lt};
            rv_pkg::SLTU:   o_result = {31'b0, w_ltu};
            rv_pkg::XOR:    o_result = i_src_a ^ i_src_b;
            rv_pkg::SRL:    o_result = i_src_a >> w_shamt;
            rv_pkg::SRA:    o_result = $signed(i_src_a) >>> w_shamt;
            rv_pkg::OR:     o_result = i_src_a | i_src_b;
            rv_pkg::AND:    o_result = i_src_a & i_src_b;
            rv_pkg::PASS_B: o_result = i_src_b;
            // branch conditions, nonzero when taken
            rv_pkg::BEQ:    o_result = {31'b0, w_eq};
            rv_pkg::BNE:    o_result = {31'b0, !w_eq};
            rv_pkg::BLT:    o_result = {31'b0, w_lt};
            rv_pkg::BGE:    o_result = {31'b0, !w_lt};
            rv_pkg::BLTU:   o_result = {31'b0, w_ltu};
            rv_pkg::BGEU:   o_result = {31'b0, !w_ltu};
            default:        o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire rv_pkg::issue_t     i_issue,
    input  wire                     i_issue_valid,
    input  wire                     i_advance,
    input  wire                     i_squash,
    output rv_pkg::dec_t            o_dec,
    output logic                    o_dec_valid
);

    rv_pkg::xlen_t   w_instr;
    rv_pkg::opcode_t w_opcode;
    rv_pkg::funct3_t w_funct3;
    rv_pkg::dec_t    w_dec;
    logic            w_known;
    logic            w_load_valid;

    // shared by OP and OP-IMM, alt selects SUB or SRA
    function automatic rv_pkg::alu_ctrl_e arith_ctrl(input rv_pkg::funct3_t f3, input logic alt);
        case (f3)
            3'b000:  arith_ctrl = alt ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  arith_ctrl = rv_pkg::SLL;
            3'b010:  arith_ctrl = rv_pkg::SLT;
            3'b011:  arith_ctrl = rv_pkg::SLTU;
            3'b100:  arith_ctrl = rv_pkg::XOR;
            3'b101:  arith_ctrl = alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  arith_ctrl = rv_pkg::OR;
            default: arith_ctrl = rv_pkg::AND;
        endcase
    endfunction

    assign w_instr  = i_issue.instr;
    assign w_opcode = w_instr[6:0];
    assign w_funct3 = w_instr[14:12];

    always_comb
    begin
        w_dec           = '0;
        w_dec.pc        = i_issue.pc;
        w_dec.pc_p4     = i_issue.pc_p4;
        w_dec.rs1_val   = i_issue.rs1_val;
        w_dec.rs2_val   = i_issue.rs2_val;
        w_dec.rd        = w_instr[11:7];
        w_dec.funct3    = w_funct3;
        w_dec.res_src   = rv_pkg::RES_ALU;
        w_dec.op1_sel   = rv_pkg::OP1_REG;
        w_dec.op2_sel   = rv_pkg::OP2_IMM;
        w_dec.alu_ctrl  = rv_pkg::ADD;
        // I-type immediate unless the group says otherwise
        w_dec.imm       = {{20{w_instr[31]}}, w_instr[31:20]};
        w_known         = 1'b1;
        case (w_opcode)
            rv_pkg::OPC_OP:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.op2_sel   = rv_pkg::OP2_REG;
                w_dec.alu_ctrl  = arith_ctrl(w_funct3, w_instr[30]);
            end
            rv_pkg::OPC_OPIMM:
            begin
                w_dec.reg_write = 1'b1;
                // only the right shift looks at bit 30 here
                w_dec.alu_ctrl  = arith_ctrl(w_funct3, (w_funct3 == 3'b101) && w_instr[30]);
            end
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.imm       = {w_instr[31:12], 12'b0};
                w_dec.op1_sel   = (w_opcode == rv_pkg::OPC_LUI) ? rv_pkg::OP1_ZERO
                                                                : rv_pkg::OP1_PC;
            end
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.jump      = 1'b1;
                w_dec.res_src   = rv_pkg::RES_PC4;
                w_dec.op1_sel   = rv_pkg::OP1_ZERO;
                w_dec.alu_ctrl  = rv_pkg::PASS_B;
                w_dec.pc_sel    = (w_opcode == rv_pkg::OPC_JALR);
                if (w_opcode == rv_pkg::OPC_JAL)
                begin
                    w_dec.imm = {{11{w_instr[31]}}, w_instr[31], w_instr[19:12],
                                 w_instr[20], w_instr[30:21], 1'b0};
                end
            end
            rv_pkg::OPC_BRANCH:
            begin
                w_dec.branch  = 1'b1;
                w_dec.op2_sel = rv_pkg::OP2_REG;
                w_dec.imm     = {{19{w_instr[31]}}, w_instr[31], w_instr[7],
                                 w_instr[30:25], w_instr[11:8], 1'b0};
                case (w_funct3)
                    3'b000:  w_dec.alu_ctrl = rv_pkg::BEQ;
                    3'b001:  w_dec.alu_ctrl = rv_pkg::BNE;
                    3'b100:  w_dec.alu_ctrl = rv_pkg::BLT;
                    3'b101:  w_dec.alu_ctrl = rv_pkg::BGE;
                    3'b110:  w_dec.alu_ctrl = rv_pkg::BLTU;
                    default: w_dec.alu_ctrl = rv_pkg::BGEU;
                endcase
            end
            rv_pkg::OPC_LOAD:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.mem_read  = 1'b1;
                w_dec.res_src   = rv_pkg::RES_MEM;
            end
            rv_pkg::OPC_STORE:
            begin
                w_dec.mem_write = 1'b1;
                w_dec.imm       = {{20{w_instr[31]}}, w_instr[31:25], w_instr[11:7]};
            end
            default:
                w_known = 1'b0;
        endcase
    end

    // a taken transfer leaving execute while decode is empty means the new
    // arrival is its shadow and must not enter
    assign w_load_valid = i_issue_valid && w_known && !(i_squash && !o_dec_valid);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_dec_valid <= 1'b0;
        end
        else if (i_advance)
        begin
            o_dec_valid <= w_load_valid;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_advance)
        begin
            o_dec <= w_dec;
        end
    end

    a_dec_valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(o_dec_valid));

endmodule

`default_nettype wire

// File: logic/rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire rv_pkg::dec_t       i_dec,
    input  wire                     i_dec_valid,
    input  wire                     i_res_ready,
    output logic                    o_advance,
    output logic                    o_squash,
    output rv_pkg::exec_res_t       o_res,
    output logic                    o_res_valid
);

    rv_pkg::dec_t  r_dec;
    logic          r_valid;
    rv_pkg::xlen_t w_op1;
    rv_pkg::xlen_t w_op2;
    rv_pkg::xlen_t w_alu_result;
    rv_pkg::xlen_t w_target_base;
    rv_pkg::xlen_t w_target_sum;
    logic          w_zero;
    logic          w_pc_src;

    // one enable for the whole pipeline
    assign o_advance = !r_valid || i_res_ready;
    assign o_squash  = r_valid && w_pc_src && o_advance;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_valid <= 1'b0;
            r_dec   <= '0;
        end
        else if (o_advance)
        begin
            if (i_dec_valid && !o_squash)
            begin
                r_valid <= 1'b1;
                r_dec   <= i_dec;
            end
            else
            begin
                // bubble, all controls low so no stale jump or write leaks out
                r_valid <= 1'b0;
                r_dec   <= '0;
            end
        end
    end

    always_comb
    begin
        case (r_dec.op1_sel)
            rv_pkg::OP1_REG: w_op1 = r_dec.rs1_val;
            rv_pkg::OP1_PC:  w_op1 = {r_dec.pc, 2'b00};
            default:         w_op1 = '0;
        endcase
    end

    assign w_op2 = (r_dec.op2_sel == rv_pkg::OP2_IMM) ? r_dec.imm : r_dec.rs2_val;

    rv_alu u_alu
    (
        .i_src_a  (w_op1),
        .i_src_b  (w_op2),
        .i_ctrl   (r_dec.alu_ctrl),
        .o_result (w_alu_result),
        .o_zero   (w_zero)
    );

    assign w_pc_src = r_dec.jump || (r_dec.branch && !w_zero);

    // jalr adds on the full rs1 value, low bits dropped after the sum
    assign w_target_base = r_dec.pc_sel ? r_dec.rs1_val : {r_dec.pc, 2'b00};
    assign w_target_sum  = w_target_base + r_dec.imm;

    always_comb
    begin
        o_res.alu_result = w_alu_result;
        o_res.reg_write  = r_dec.reg_write;
        o_res.mem_read   = r_dec.mem_read;
        o_res.mem_write  = r_dec.mem_write;
        o_res.rd         = r_dec.rd;
        o_res.pc_p4      = r_dec.pc_p4;
        o_res.res_src    = r_dec.res_src;
        o_res.funct3     = r_dec.funct3;
        o_res.rs2_val    = r_dec.rs2_val;
        o_res.pc_src     = w_pc_src;
        o_res.pc_target  = w_target_sum[31:2];
    end

    assign o_res_valid = r_valid;

    a_res_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_res));

    a_redirect_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_res.pc_src |-> o_res_valid);

endmodule

`default_nettype wire

// File: logic/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire rv_pkg::issue_t     i_issue,
    input  wire                     i_issue_valid,
    output logic                    o_issue_ready,
    output rv_pkg::exec_res_t       o_res,
    output logic                    o_res_valid,
    input  wire                     i_res_ready
);

    rv_pkg::dec_t w_dec;
    logic         w_dec_valid;
    logic         w_advance;
    logic         w_squash;

    rv_decode u_decode
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (i_issue),
        .i_issue_valid (i_issue_valid),
        .i_advance     (w_advance),
        .i_squash      (w_squash),
        .o_dec         (w_dec),
        .o_dec_valid   (w_dec_valid)
    );

    rv_exec u_exec
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_dec       (w_dec),
        .i_dec_valid (w_dec_valid),
        .i_res_ready (i_res_ready),
        .o_advance   (w_advance),
        .o_squash    (w_squash),
        .o_res       (o_res),
        .o_res_valid (o_res_valid)
    );

    // the source may issue whenever the pipeline moves
    assign o_issue_ready = w_advance;

endmodule

`default_nettype wire

// File: tb/tb_rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_top;

    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_PERIOD   = 10;
    localparam int WATCHDOG_NS  = (NUM_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD;

    typedef enum logic [3:0] {
        G_OP, G_OPIMM, G_LUI, G_AUIPC, G_JAL, G_JALR, G_BRANCH, G_LOAD, G_STORE
    } group_e;

    typedef struct packed {
        group_e            grp;
        rv_pkg::exec_res_t res;
    } expect_t;

    logic              i_clk;
    logic              i_rst_n;
    rv_pkg::issue_t    i_issue;
    logic              i_issue_valid;
    logic              o_issue_ready;
    rv_pkg::exec_res_t o_res;
    logic              o_res_valid;
    logic              i_res_ready;

    expect_t           offer_exp;
    expect_t           exp_q[$];
    logic              offer_taken;
    logic              shadow_pending;
    logic              hold_prev;
    rv_pkg::exec_res_t res_prev;
    logic              occ_dec;
    logic              occ_dec_drop;
    logic              occ_ex;
    int                accepted;

    rv_exec_top i_dut
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (i_issue),
        .i_issue_valid (i_issue_valid),
        .o_issue_ready (o_issue_ready),
        .o_res         (o_res),
        .o_res_valid   (o_res_valid),
        .i_res_ready   (i_res_ready)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("error: time %0t signal %s got %08h expected %08h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok)
        else
        begin
            $display("failure at time %0t: %s", $time, what);
            stop_on_error();
        end
    endtask

    function automatic rv_pkg::xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                                input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
        rv_pkg::xlen_t res;
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'b0, $signed(a) < $signed(b)};
            3'b011:  res = {31'b0, a < b};
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default:
            begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::xlen_t a,
                                          input rv_pkg::xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // small, small negative, large negative or anything
    function automatic rv_pkg::xlen_t rand_operand();
        case ($urandom_range(3))
            0:       return 32'($urandom_range(31));
            1:       return 32'hffff_ffe0 | 32'($urandom_range(31));
            2:       return {1'b1, 31'($urandom)};
            default: return $urandom;
        endcase
    endfunction

    // builds one random instruction and its expected result
    task automatic make_offer();
        group_e            grp;
        logic [2:0]        f3;
        logic              alt;
        logic [4:0]        rd;
        logic [11:0]       imm12;
        logic [20:0]       off;
        rv_pkg::xlen_t     imm;
        rv_pkg::xlen_t     word;
        rv_pkg::xlen_t     a;
        rv_pkg::xlen_t     b;
        rv_pkg::xlen_t     pc_byte;
        rv_pkg::xlen_t     target;
        rv_pkg::exec_res_t r;

        grp   = group_e'(4'($urandom_range(8)));
        f3    = 3'($urandom);
        alt   = 1'b0;
        rd    = 5'($urandom);
        imm12 = 12'($urandom);
        off   = 21'($urandom);
        off[0] = 1'b0;
        a     = rand_operand();
        b     = ($urandom_range(3) == 0) ? a : rand_operand();
        i_issue.pc      = 30'($urandom);
        i_issue.pc_p4   = i_issue.pc + 30'd1;
        i_issue.rs1_val = a;
        i_issue.rs2_val = b;
        pc_byte = {i_issue.pc, 2'b00};
        target  = '0;
        r           = '0;
        r.rd        = rd;
        r.rs2_val   = b;
        r.pc_p4     = i_issue.pc_p4;
        r.reg_write = 1'b1;
        r.res_src   = rv_pkg::RES_ALU;
        case (grp)
            G_OP:
            begin
                alt  = (f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1;
                word = {1'b0, alt, 5'b0, 5'($urandom), 5'($urandom), f3, rd, rv_pkg::OPC_OP};
                r.alu_result = alu_model(f3, alt, a, b);
            end
            G_OPIMM:
            begin
                if (f3 == 3'b001 || f3 == 3'b101)
                begin
                    alt   = (f3 == 3'b101) && $urandom_range(1) == 1;
                    imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
                end
                imm  = {{20{imm12[11]}}, imm12};
                word = {imm12, 5'($urandom), f3, rd, rv_pkg::OPC_OPIMM};
                r.alu_result = alu_model(f3, alt, a, imm);
            end
            G_LUI, G_AUIPC:
            begin
                word = {20'($urandom), rd, (grp == G_LUI) ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC};
                r.alu_result = {word[31:12], 12'b0} + ((grp == G_LUI) ? 32'd0 : pc_byte);
            end
            G_JAL, G_JALR:
            begin
                r.pc_src  = 1'b1;
                r.res_src = rv_pkg::RES_PC4;
                if (grp == G_JAL)
                begin
                    word   = {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
                    target = pc_byte + {{11{off[20]}}, off};
                end
                else
                begin
                    word   = {imm12, 5'($urandom), 3'b000, rd, rv_pkg::OPC_JALR};
                    target = a + {{20{imm12[11]}}, imm12};
                end
            end
            G_BRANCH:
            begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;
                word = {off[12], off[10:5], 5'($urandom), 5'($urandom), f3, off[4:1], off[11],
                        rv_pkg::OPC_BRANCH};
                r.reg_write = 1'b0;
                r.pc_src    = branch_taken(f3, a, b);
                target      = pc_byte + {{19{off[12]}}, off[12:0]};
            end
            G_LOAD:
            begin
                if (f3 == 3'b011 || f3[2:1] == 2'b11)
                    f3[1] = 1'b0;
                word = {imm12, 5'($urandom), f3, rd, rv_pkg::OPC_LOAD};
                r.mem_read   = 1'b1;
                r.res_src    = rv_pkg::RES_MEM;
                r.alu_result = a + {{20{imm12[11]}}, imm12};
            end
            default:
            begin
                f3[2] = 1'b0;
                if (f3 == 3'b011)
                    f3 = 3'b010;
                word = {imm12[11:5], 5'($urandom), 5'($urandom), f3, imm12[4:0],
                        rv_pkg::OPC_STORE};
                r.reg_write  = 1'b0;
                r.mem_write  = 1'b1;
                r.alu_result = a + {{20{imm12[11]}}, imm12};
            end
        endcase
        r.funct3        = f3;
        r.pc_target     = target[31:2];
        i_issue.instr   = word;
        offer_exp.grp   = grp;
        offer_exp.res   = r;
    endtask

    task automatic compare_result(input expect_t e);
        check_value("o_res.reg_write", 32'(o_res.reg_write), 32'(e.res.reg_write));
        check_value("o_res.mem_read", 32'(o_res.mem_read), 32'(e.res.mem_read));
        check_value("o_res.mem_write", 32'(o_res.mem_write), 32'(e.res.mem_write));
        check_value("o_res.pc_src", 32'(o_res.pc_src), 32'(e.res.pc_src));
        if (e.res.reg_write)
        begin
            check_value("o_res.rd", 32'(o_res.rd), 32'(e.res.rd));
            check_value("o_res.res_src", 32'(o_res.res_src), 32'(e.res.res_src));
        end
        if (!(e.grp inside {G_JAL, G_JALR, G_BRANCH}))
            check_value("o_res.alu_result", o_res.alu_result, e.res.alu_result);
        if (e.grp inside {G_JAL, G_JALR})
            check_value("o_res.pc_p4", 32'(o_res.pc_p4), 32'(e.res.pc_p4));
        if (e.res.pc_src)
            check_value("o_res.pc_target", 32'(o_res.pc_target), 32'(e.res.pc_target));
        if (e.res.mem_read || e.res.mem_write)
            check_value("o_res.funct3", 32'(o_res.funct3), 32'(e.res.funct3));
        if (e.res.mem_write)
            check_value("o_res.rs2_val", o_res.rs2_val, e.res.rs2_val);
    endtask

    // reference model and scoreboard, sees only the two handshakes
    always @(posedge i_clk)
    begin : monitor
        expect_t e;
        logic    drop;
        logic    adv;
        if (i_rst_n)
        begin
            adv = !occ_ex || i_res_ready;
            check_value("o_issue_ready", 32'(o_issue_ready), 32'(adv));
            check_value("o_res_valid", 32'(o_res_valid), 32'(occ_ex));
            if (hold_prev)
            begin
                check_true(o_res_valid, "o_res_valid dropped before the result was taken");
                assert (o_res === res_prev)
                else
                begin
                    $display("error: time %0t signal o_res got %h expected %h",
                             $time, o_res, res_prev);
                    stop_on_error();
                end
            end
            hold_prev   = o_res_valid && !i_res_ready;
            res_prev    = o_res;
            offer_taken = i_issue_valid && o_issue_ready;
            drop        = offer_taken && shadow_pending;
            if (o_res_valid && i_res_ready)
            begin
                check_true(exp_q.size() != 0, "a result came out with none expected");
                e = exp_q.pop_front();
                compare_result(e);
            end
            // the taken transfer has left the pipeline
            if (exp_q.size() == 0)
                shadow_pending = 1'b0;
            if (offer_taken)
            begin
                accepted++;
                if (drop)
                begin
                    shadow_pending = 1'b0;
                end
                else
                begin
                    exp_q.push_back(offer_exp);
                    shadow_pending = offer_exp.res.pc_src;
                end
            end
            // occupancy copy, a shadow entry never reaches execute
            if (adv)
            begin
                occ_ex       = occ_dec && !occ_dec_drop;
                occ_dec      = offer_taken;
                occ_dec_drop = drop;
            end
            check_true(exp_q.size() <= 2, "more than two instructions in flight");
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        void'($urandom(28));
        i_rst_n        = 1'b0;
        i_issue        = '0;
        i_issue_valid  = 1'b0;
        i_res_ready    = 1'b0;
        offer_exp      = '0;
        offer_taken    = 1'b0;
        shadow_pending = 1'b0;
        hold_prev      = 1'b0;
        res_prev       = '0;
        occ_dec        = 1'b0;
        occ_dec_drop   = 1'b0;
        occ_ex         = 1'b0;
        accepted       = 0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_value("o_res_valid", 32'(o_res_valid), 32'd0);
        check_value("o_issue_ready", 32'(o_issue_ready), 32'd1);

        while (accepted < NUM_INSTR)
        begin
            // an offer stays on the bus until it is accepted
            if (!i_issue_valid || offer_taken)
            begin
                i_issue_valid = ($urandom_range(99) < 85);
                if (i_issue_valid)
                    make_offer();
            end
            i_res_ready = ($urandom_range(99) < 80);
            @(negedge i_clk);
        end
        i_issue_valid = 1'b0;
        while (exp_q.size() != 0)
        begin
            i_res_ready = ($urandom_range(99) < 80);
            @(negedge i_clk);
        end
        i_res_ready = 1'b1;
        repeat (5) @(negedge i_clk);
        check_value("o_res_valid", 32'(o_res_valid), 32'd0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_decode.sv
logic/rv_exec.sv
logic/rv_exec_top.sv
tb/tb_rv_exec_top.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_exec_top -Mdir "$BUILD_DIR" -o sim_exec -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_exec" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation finished without failures"
exit 0
